// ==== bram_1rport_1wport.sv ====
`timescale 1ns/1ps
`default_nettype none

module bram_1rport_1wport #(
    parameter int INNER_WIDTH = 64,
    parameter int OUTER_WIDTH = 16
) (
    input  logic                            CLK,
    input  logic                            nRST,

    input  logic                            ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0]  rindex,
    output logic [INNER_WIDTH-1:0]          rdata,

    input  logic [INNER_WIDTH/8-1:0]        wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0]  windex,
    input  logic [INNER_WIDTH-1:0]          wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // byte-granular write
    always_ff @(posedge CLK) begin
        for (int b = 0; b < INNER_WIDTH/8; b++) begin
            if (wen_byte[b]) begin
                mem[windex][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // registered read, same-index write returns old data
    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            rdata <= '0;
        end
        else if (ren) begin
            rdata <= mem[rindex];
        end
    end

endmodule

`default_nettype wire

// ==== btb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

module btb (
    input  logic                                        CLK,
    input  logic                                        nRST,

    input  corep::ASID_t                                arch_asid,

    // read request
    input  logic                                        read_req_valid,
    input  corep::fetch_idx_t                           read_req_fetch_index,

    // read response
    input  corep::PC38_t                                read_resp_pc38,
    output corep::BTB_info_t [`FETCH_LANES-1:0]         read_resp_info_by_lane,
    output logic [`FETCH_LANES-1:0]                     read_resp_hit_by_lane,
    output corep::BTB_way_idx_t [`FETCH_LANES-1:0]      read_resp_hit_way_by_lane,

    // training update
    input  logic                                        update_valid,
    input  corep::PC38_t                                update_pc38,
    input  corep::BTB_info_t                            update_btb_info,
    input  logic                                        update_hit,
    input  corep::BTB_way_idx_t                         update_hit_way
);

    import corep::*;

    // entries sit in whole-byte slots so one entry writes alone
    localparam int ENTRY_BITS  = $bits(BTB_entry_t);
    localparam int ENTRY_BYTES = (ENTRY_BITS + 7) / 8;

    // ------------------------------------------------------------
    // hashes
    // ------------------------------------------------------------

    function automatic BTB_idx_t index_hash(fetch_idx_t idx, ASID_t asid);
        return idx[`LOG_BTB_SETS-1:0] ^ asid[`LOG_BTB_SETS-1:0];
    endfunction

    function automatic BTB_tag_t tag_hash(PC38_t pc38, ASID_t asid);
        return pc38[`LOG_BTB_SETS+`LOG_FETCH_LANES +: `TAG_WIDTH] ^ asid;
    endfunction

    logic [`FETCH_LANES-1:0][`BTB_ASSOC-1:0][ENTRY_BYTES*8-1:0] bram_rdata;
    logic [`FETCH_LANES-1:0][`BTB_ASSOC-1:0][ENTRY_BYTES*8-1:0] bram_wdata;
    logic [`FETCH_LANES-1:0][`BTB_ASSOC-1:0][ENTRY_BYTES-1:0]   bram_wen_byte;
    BTB_set_t       bram_read_set;
    BTB_tag_t       resp_tag;

    // update side
    BTB_idx_t       update_index;
    fetch_lane_t    update_lane;
    BTB_entry_t     update_entry;
    BTB_way_idx_t   update_way;
    BTB_way_idx_t   victim_way;
    BTB_plru_t      plru_next;

    // tree per set and lane
    BTB_plru_t      plru_array [`BTB_SETS][`FETCH_LANES];

    // ------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------

    always_comb begin
        resp_tag = tag_hash(read_resp_pc38, arch_asid);
        for (int lane = 0; lane < `FETCH_LANES; lane++) begin
            for (int way = 0; way < `BTB_ASSOC; way++) begin
                bram_read_set[lane][way] = BTB_entry_t'(bram_rdata[lane][way][ENTRY_BITS-1:0]);
            end
        end

        for (int lane = 0; lane < `FETCH_LANES; lane++) begin
            read_resp_info_by_lane[lane]    = bram_read_set[lane][0].info;
            read_resp_hit_by_lane[lane]     = 1'b0;
            read_resp_hit_way_by_lane[lane] = '0;
            // walk downward so the lowest matching way is kept
            for (int way = `BTB_ASSOC-1; way >= 0; way--) begin
                if (bram_read_set[lane][way].info.action != BTB_NONE &&
                    bram_read_set[lane][way].tag == resp_tag) begin
                    read_resp_info_by_lane[lane]    = bram_read_set[lane][way].info;
                    read_resp_hit_by_lane[lane]     = 1'b1;
                    read_resp_hit_way_by_lane[lane] = BTB_way_idx_t'(way);
                end
            end
        end
    end

    // ------------------------------------------------------------
    // update
    // ------------------------------------------------------------

    always_comb begin
        update_index     = index_hash(update_pc38[`PC_WIDTH-1:`LOG_FETCH_LANES], arch_asid);
        update_lane      = fetch_lane_bits(update_pc38);
        update_entry.info = update_btb_info;
        update_entry.tag  = tag_hash(update_pc38, arch_asid);
        update_way       = update_hit ? update_hit_way : victim_way;

        bram_wen_byte = '0;
        if (update_valid) begin
            bram_wen_byte[update_lane][update_way] = '1;
        end

        // same data in every slot, the enables pick one
        for (int lane = 0; lane < `FETCH_LANES; lane++) begin
            for (int way = 0; way < `BTB_ASSOC; way++) begin
                bram_wdata[lane][way] = '0;
                bram_wdata[lane][way][ENTRY_BITS-1:0] = update_entry;
            end
        end
    end

    plru_updater plru_updater_i (
        .plru_in     (plru_array[update_index][update_lane]),
        .new_valid   (update_valid & ~update_hit),
        .new_way     (victim_way),
        .touch_valid (update_valid & update_hit),
        .touch_way   (update_hit_way),
        .plru_out    (plru_next)
    );

    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            for (int set = 0; set < `BTB_SETS; set++) begin
                for (int lane = 0; lane < `FETCH_LANES; lane++) begin
                    plru_array[set][lane] <= '0;
                end
            end
        end
        else if (update_valid) begin
            plru_array[update_index][update_lane] <= plru_next;
        end
    end

    bram_1rport_1wport #(
        .INNER_WIDTH ($bits(bram_rdata)),
        .OUTER_WIDTH (`BTB_SETS)
    ) bram_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .ren      (read_req_valid),
        .rindex   (index_hash(read_req_fetch_index, arch_asid)),
        .rdata    (bram_rdata),
        .wen_byte (bram_wen_byte),
        .windex   (update_index),
        .wdata    (bram_wdata)
    );

endmodule

`default_nettype wire

// ==== btb_consts.svh ====
`ifndef BTB_CONSTS_SVH
`define BTB_CONSTS_SVH

// ------------------------------------------------------------
// fetch block geometry
// ------------------------------------------------------------

// instructions per fetch block
`define FETCH_LANES         4
`define LOG_FETCH_LANES     2

// instruction-word pc
`define PC_WIDTH            38

// ------------------------------------------------------------
// btb geometry
// ------------------------------------------------------------

`define BTB_SETS            16
`define LOG_BTB_SETS        4
`define BTB_ASSOC           4
`define ASID_WIDTH          8
`define TAG_WIDTH           8

// info payload, low target bits or indirect index plus hint
`define TARGET_WIDTH        12
`define INDIRECT_HINT_WIDTH 4

`endif

// ==== corep.sv ====
`default_nettype none

`include "btb_consts.svh"

package corep;

    // ------------------------------------------------------------
    // pc and fetch types
    // ------------------------------------------------------------

    typedef logic [`PC_WIDTH-1:0]                   PC38_t;
    typedef logic [`ASID_WIDTH-1:0]                 ASID_t;
    typedef logic [`PC_WIDTH-`LOG_FETCH_LANES-1:0]  fetch_idx_t;
    typedef logic [`LOG_FETCH_LANES-1:0]            fetch_lane_t;

    // ------------------------------------------------------------
    // btb types
    // ------------------------------------------------------------

    typedef logic [`LOG_BTB_SETS-1:0]       BTB_idx_t;
    typedef logic [`TAG_WIDTH-1:0]          BTB_tag_t;
    typedef logic [$clog2(`BTB_ASSOC)-1:0]  BTB_way_idx_t;
    typedef logic [`BTB_ASSOC-2:0]          BTB_plru_t;

    // none must stay zero, a zero action marks an empty entry
    typedef enum logic [2:0] {
        BTB_NONE           = 3'd0,
        BTB_COND_TAKEN     = 3'd1,
        BTB_COND_NOT_TAKEN = 3'd2,
        BTB_JUMP           = 3'd3,
        BTB_CALL           = 3'd4,
        BTB_INDIRECT       = 3'd5
    } BTB_action_t;

    typedef struct packed {
        logic [`INDIRECT_HINT_WIDTH-1:0]                hint;
        logic [`TARGET_WIDTH-`INDIRECT_HINT_WIDTH-1:0]  index;
    } BTB_indirect_t;

    // direct actions read target_lo, indirect reads the table index
    typedef union packed {
        logic [`TARGET_WIDTH-1:0]   target_lo;
        BTB_indirect_t              indirect;
    } BTB_payload_t;

    typedef struct packed {
        BTB_action_t    action;
        BTB_payload_t   payload;
    } BTB_info_t;

    typedef struct packed {
        BTB_info_t  info;
        BTB_tag_t   tag;
    } BTB_entry_t;

    typedef BTB_entry_t [`FETCH_LANES-1:0][`BTB_ASSOC-1:0] BTB_set_t;

    function automatic fetch_lane_t fetch_lane_bits(PC38_t pc38);
        return pc38[`LOG_FETCH_LANES-1:0];
    endfunction

endpackage

`default_nettype wire

// ==== fetch_pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

module fetch_pc_gen (
    input  logic                CLK,
    input  logic                nRST,

    input  logic                fetch_en,
    input  logic                start_valid,
    input  corep::PC38_t        start_pc,

    input  logic                redirect_valid,
    input  corep::PC38_t        redirect_pc,

    output logic                read_req_valid,
    output corep::fetch_idx_t   read_req_fetch_index,

    output logic                resp_valid,
    output corep::PC38_t        resp_pc38
);

    import corep::*;

    // pc to request while no response is in flight
    PC38_t      pc_q;
    PC38_t      next_pc;
    fetch_idx_t seq_idx;
    logic       started;

    always_comb begin
        // aligned up to the following block
        seq_idx = resp_pc38[`PC_WIDTH-1:`LOG_FETCH_LANES] + 1'b1;

        if (start_valid) begin
            next_pc = start_pc;
        end
        else if (redirect_valid) begin
            next_pc = redirect_pc;
        end
        else if (resp_valid) begin
            next_pc = {seq_idx, {`LOG_FETCH_LANES{1'b0}}};
        end
        else begin
            next_pc = pc_q;
        end

        // the start cycle only loads the pc
        read_req_valid       = fetch_en & started & ~start_valid;
        read_req_fetch_index = next_pc[`PC_WIDTH-1:`LOG_FETCH_LANES];
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            started    <= 1'b0;
            resp_valid <= 1'b0;
        end
        else begin
            started    <= started | start_valid;
            resp_valid <= read_req_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (start_valid | resp_valid) begin
            pc_q <= next_pc;
        end
        if (read_req_valid) begin
            resp_pc38 <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== fetch_predict_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

module fetch_predict_top (
    input  logic                CLK,
    input  logic                nRST,

    input  logic                fetch_en,
    input  corep::ASID_t        arch_asid,
    input  logic                start_valid,
    input  corep::PC38_t        start_pc,

    input  logic                update_valid,
    input  corep::PC38_t        update_pc,
    input  corep::BTB_info_t    update_info,
    input  logic                update_hit,
    input  corep::BTB_way_idx_t update_hit_way,

    output logic                fetch_valid,
    output corep::PC38_t        fetch_pc,
    output logic                pred_valid,
    output corep::fetch_lane_t  pred_lane,
    output corep::PC38_t        pred_target
);

    import corep::*;

    logic                           read_req_valid;
    fetch_idx_t                     read_req_fetch_index;
    logic                           redirect_valid;
    PC38_t                          redirect_pc;
    BTB_info_t [`FETCH_LANES-1:0]   info_by_lane;
    logic [`FETCH_LANES-1:0]        hit_by_lane;

    fetch_pc_gen fetch_pc_gen_i (
        .CLK                  (CLK),
        .nRST                 (nRST),
        .fetch_en             (fetch_en),
        .start_valid          (start_valid),
        .start_pc             (start_pc),
        .redirect_valid       (redirect_valid),
        .redirect_pc          (redirect_pc),
        .read_req_valid       (read_req_valid),
        .read_req_fetch_index (read_req_fetch_index),
        .resp_valid           (fetch_valid),
        .resp_pc38            (fetch_pc)
    );

    // hit way only matters to the training side of the core
    btb btb_i (
        .CLK                       (CLK),
        .nRST                      (nRST),
        .arch_asid                 (arch_asid),
        .read_req_valid            (read_req_valid),
        .read_req_fetch_index      (read_req_fetch_index),
        .read_resp_pc38            (fetch_pc),
        .read_resp_info_by_lane    (info_by_lane),
        .read_resp_hit_by_lane     (hit_by_lane),
        .read_resp_hit_way_by_lane (),
        .update_valid              (update_valid),
        .update_pc38               (update_pc),
        .update_btb_info           (update_info),
        .update_hit                (update_hit),
        .update_hit_way            (update_hit_way)
    );

    fetch_redirect fetch_redirect_i (
        .resp_valid     (fetch_valid),
        .resp_pc38      (fetch_pc),
        .info_by_lane   (info_by_lane),
        .hit_by_lane    (hit_by_lane),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pred_valid     (pred_valid),
        .pred_lane      (pred_lane),
        .pred_target    (pred_target)
    );

endmodule

`default_nettype wire

// ==== fetch_redirect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

module fetch_redirect (
    input  logic                                resp_valid,
    input  corep::PC38_t                        resp_pc38,
    input  corep::BTB_info_t [`FETCH_LANES-1:0] info_by_lane,
    input  logic [`FETCH_LANES-1:0]             hit_by_lane,

    output logic                                redirect_valid,
    output corep::PC38_t                        redirect_pc,

    output logic                                pred_valid,
    output corep::fetch_lane_t                  pred_lane,
    output corep::PC38_t                        pred_target
);

    import corep::*;

    function automatic logic is_taken(BTB_action_t action);
        case (action)
            BTB_COND_TAKEN, BTB_JUMP, BTB_CALL, BTB_INDIRECT: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    fetch_lane_t    start_lane;
    logic           found;
    fetch_lane_t    found_lane;
    BTB_info_t      found_info;
    logic           found_indirect;

    // ------------------------------------------------------------
    // lane scan
    // ------------------------------------------------------------

    always_comb begin
        start_lane = fetch_lane_bits(resp_pc38);
        found      = 1'b0;
        found_lane = '0;
        found_info = info_by_lane[0];

        // downward walk leaves the lowest taken lane
        for (int lane = `FETCH_LANES-1; lane >= 0; lane--) begin
            if (hit_by_lane[lane] && lane >= start_lane &&
                is_taken(info_by_lane[lane].action)) begin
                found      = 1'b1;
                found_lane = fetch_lane_t'(lane);
                found_info = info_by_lane[lane];
            end
        end

        found_indirect = found_info.action == BTB_INDIRECT;

        // direct target replaces the low pc bits
        redirect_pc    = {resp_pc38[`PC_WIDTH-1:`TARGET_WIDTH], found_info.payload.target_lo};
        redirect_valid = resp_valid & found & ~found_indirect;

        pred_valid = resp_valid & found;
        pred_lane  = found_lane;
        if (found_indirect) begin
            pred_target = PC38_t'(found_info.payload.indirect.index);
        end
        else begin
            pred_target = redirect_pc;
        end
    end

endmodule

`default_nettype wire

// ==== plru_updater.sv ====
`timescale 1ns/1ps
`default_nettype none

module plru_updater (
    input  corep::BTB_plru_t    plru_in,

    input  logic                new_valid,
    output corep::BTB_way_idx_t new_way,

    input  logic                touch_valid,
    input  corep::BTB_way_idx_t touch_way,

    output corep::BTB_plru_t    plru_out
);

    import corep::*;

    // way whose path gets flipped
    BTB_way_idx_t used_way;

    always_comb begin
        // bit 0 picks the half, bit 1 or 2 the way inside it
        new_way[1] = plru_in[0];
        new_way[0] = plru_in[0] ? plru_in[2] : plru_in[1];

        // a touch wins over an allocation
        used_way = touch_valid ? touch_way : new_way;

        plru_out = plru_in;
        if (touch_valid | new_valid) begin
            plru_out[0] = ~used_way[1];
            if (used_way[1]) begin
                plru_out[2] = ~used_way[0];
            end
            else begin
                plru_out[1] = ~used_way[0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_tb_fetch_predict

verilator --binary --timing -Wno-fatal --top-module tb_fetch_predict \
    -f src.f --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// ==== src.f ====
+incdir+.
corep.sv
plru_updater.sv
bram_1rport_1wport.sv
btb.sv
fetch_pc_gen.sv
fetch_redirect.sv
fetch_predict_top.sv
tb_fetch_predict.sv

// ==== tb_fetch_predict.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

module tb_fetch_predict;

    import corep::*;

    localparam int MAX_TESTS    = 16;
    localparam int MAX_UPDATES  = 32;
    localparam int RESET_CYCLES = 10;

    logic           CLK;
    logic           nRST;
    logic           fetch_en;
    ASID_t          arch_asid;
    logic           start_valid;
    PC38_t          start_pc;
    logic           update_valid;
    PC38_t          update_pc;
    BTB_info_t      update_info;
    logic           update_hit;
    BTB_way_idx_t   update_hit_way;
    logic           fetch_valid;
    PC38_t          fetch_pc;
    logic           pred_valid;
    fetch_lane_t    pred_lane;
    PC38_t          pred_target;

    // test table
    string          test_name [MAX_TESTS];
    logic [7:0]     test_asid [MAX_TESTS];
    logic [37:0]    test_pc   [MAX_TESTS];
    int             num_tests;

    // training updates tagged with the test that applies them
    int             upd_test    [MAX_UPDATES];
    logic [37:0]    upd_pc      [MAX_UPDATES];
    logic [2:0]     upd_action  [MAX_UPDATES];
    logic [11:0]    upd_payload [MAX_UPDATES];
    logic           upd_hit     [MAX_UPDATES];
    logic [1:0]     upd_way     [MAX_UPDATES];
    int             num_updates;

    // reference btb contents
    logic [2:0]     ref_action  [`BTB_SETS][`FETCH_LANES][`BTB_ASSOC];
    logic [11:0]    ref_payload [`BTB_SETS][`FETCH_LANES][`BTB_ASSOC];
    logic [7:0]     ref_tag     [`BTB_SETS][`FETCH_LANES][`BTB_ASSOC];
    logic [2:0]     ref_plru    [`BTB_SETS][`FETCH_LANES];

    int             cycle_count;
    int             test_errors;
    int             tests_passed;
    int             tests_failed;

    fetch_predict_top fetch_predict_top_i (
        .CLK            (CLK),
        .nRST           (nRST),
        .fetch_en       (fetch_en),
        .arch_asid      (arch_asid),
        .start_valid    (start_valid),
        .start_pc       (start_pc),
        .update_valid   (update_valid),
        .update_pc      (update_pc),
        .update_info    (update_info),
        .update_hit     (update_hit),
        .update_hit_way (update_hit_way),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .pred_valid     (pred_valid),
        .pred_lane      (pred_lane),
        .pred_target    (pred_target)
    );

    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count > 40 * num_tests + RESET_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    function automatic logic [1:0] pick_victim(logic [2:0] tree);
        // bit 0 picks the half and bit 1 or 2 the way
        if (tree[0]) begin
            return {1'b1, tree[2]};
        end
        return {1'b0, tree[1]};
    endfunction

    function automatic logic [2:0] point_away(logic [2:0] tree, logic [1:0] way);
        logic [2:0] t;
        t    = tree;
        t[0] = ~way[1];
        if (way[1]) begin
            t[2] = ~way[0];
        end
        else begin
            t[1] = ~way[0];
        end
        return t;
    endfunction

    task automatic clear_reference();
        for (int s = 0; s < `BTB_SETS; s++) begin
            for (int l = 0; l < `FETCH_LANES; l++) begin
                ref_plru[s][l] = 3'b000;
                for (int w = 0; w < `BTB_ASSOC; w++) begin
                    ref_action[s][l][w]  = 3'd0;
                    ref_payload[s][l][w] = 12'h000;
                    ref_tag[s][l][w]     = 8'h00;
                end
            end
        end
    endtask

    task automatic train_reference(input logic [37:0] pc, input logic [7:0] asid,
                                   input logic [2:0] action, input logic [11:0] payload,
                                   input logic hit, input logic [1:0] hit_way);
        int         set;
        int         lane;
        logic [1:0] way;
        set  = pc[5:2] ^ asid[3:0];
        lane = pc[1:0];
        way  = hit ? hit_way : pick_victim(ref_plru[set][lane]);
        ref_action[set][lane][way]  = action;
        ref_payload[set][lane][way] = payload;
        ref_tag[set][lane][way]     = pc[13:6] ^ asid;
        ref_plru[set][lane]         = point_away(ref_plru[set][lane], way);
    endtask

    task automatic predict_reference(input logic [37:0] pc, input logic [7:0] asid,
                                     output logic valid, output logic [1:0] lane_out,
                                     output logic [37:0] target, output logic [37:0] next_pc);
        int         set;
        int         hit_way;
        logic [7:0] tag;
        logic [2:0] act;
        set      = pc[5:2] ^ asid[3:0];
        tag      = pc[13:6] ^ asid;
        valid    = 1'b0;
        lane_out = 2'd0;
        target   = '0;
        next_pc  = {pc[37:2] + 36'd1, 2'b00};
        for (int lane = int'(pc[1:0]); lane < `FETCH_LANES && !valid; lane++) begin
            hit_way = -1;
            for (int way = 0; way < `BTB_ASSOC; way++) begin
                if (hit_way < 0 && ref_action[set][lane][way] != 3'd0 &&
                    ref_tag[set][lane][way] == tag) begin
                    hit_way = way;
                end
            end
            if (hit_way >= 0) begin
                act = ref_action[set][lane][hit_way];
                // cond-taken, jump, call and indirect count as taken
                if (act == 3'd1 || act == 3'd3 || act == 3'd4 || act == 3'd5) begin
                    valid    = 1'b1;
                    lane_out = lane[1:0];
                    if (act == 3'd5) begin
                        target = {30'd0, ref_payload[set][lane][hit_way][7:0]};
                    end
                    else begin
                        target  = {pc[37:12], ref_payload[set][lane][hit_way]};
                        next_pc = target;
                    end
                end
            end
        end
    endtask

    // ------------------------------------------------------------
    // table and checking
    // ------------------------------------------------------------

    task automatic add_test(input string name, input logic [7:0] asid, input logic [37:0] pc);
        test_name[num_tests] = name;
        test_asid[num_tests] = asid;
        test_pc[num_tests]   = pc;
        num_tests++;
    endtask

    task automatic attach_update(input logic [37:0] pc, input logic [2:0] action,
                                 input logic [11:0] payload, input logic hit,
                                 input logic [1:0] way);
        upd_test[num_updates]    = num_tests - 1;
        upd_pc[num_updates]      = pc;
        upd_action[num_updates]  = action;
        upd_payload[num_updates] = payload;
        upd_hit[num_updates]     = hit;
        upd_way[num_updates]     = way;
        num_updates++;
    endtask

    task automatic load_tests();
        logic [3:0] hint;
        hint = 4'($urandom());
        add_test("reset_miss", 8'h00, 38'h0100);
        add_test("jump_lane2", 8'h3c, 38'h2a44);
        attach_update(38'h2a46, 3'd3, 12'h5c0, 1'b0, 2'd0);
        add_test("asid_miss", 8'h5a, 38'h2a44);
        add_test("lane3_skip", 8'h3c, 38'h3103);
        attach_update(38'h3101, 3'd1, 12'h111, 1'b0, 2'd0);
        attach_update(38'h3102, 3'd2, 12'h222, 1'b0, 2'd0);
        attach_update(38'h3103, 3'd4, 12'h333, 1'b0, 2'd0);
        add_test("not_taken_skip", 8'h3c, 38'h3102);
        add_test("lane1_taken", 8'h3c, 38'h3100);
        // five tags into set 0 lane 1
        add_test("plru_evict", 8'h00, 38'h0041);
        attach_update(38'h0041, 3'd3, 12'h0a1, 1'b0, 2'd0);
        attach_update(38'h0441, 3'd3, 12'h0a2, 1'b0, 2'd0);
        attach_update(38'h0841, 3'd3, 12'h0a3, 1'b0, 2'd0);
        attach_update(38'h0c41, 3'd3, 12'h0a4, 1'b0, 2'd0);
        attach_update(38'h1041, 3'd3, 12'h0a5, 1'b0, 2'd0);
        // only the first tag is gone
        add_test("plru_keep", 8'h00, 38'h1041);
        add_test("plru_keep_2nd", 8'h00, 38'h0441);
        add_test("plru_keep_3rd", 8'h00, 38'h0841);
        add_test("plru_keep_4th", 8'h00, 38'h0c41);
        add_test("hit_rewrite", 8'h00, 38'h1041);
        attach_update(38'h1041, 3'd3, 12'h7f0, 1'b1, 2'd0);
        add_test("indirect", 8'h21, 38'h5200);
        attach_update(38'h5202, 3'd5, {hint, 8'h9b}, 1'b0, 2'd0);
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", name, what,
                     expected, actual);
            test_errors++;
        end
    endtask

    task automatic run_test(input int t);
        logic           exp_valid;
        logic [1:0]     exp_lane;
        logic [37:0]    exp_target;
        logic [37:0]    exp_next;
        test_errors = 0;
        arch_asid   = test_asid[t];
        for (int u = 0; u < num_updates; u++) begin
            if (upd_test[u] == t) begin
                update_valid   = 1'b1;
                update_pc      = upd_pc[u];
                update_info    = BTB_info_t'({upd_action[u], upd_payload[u]});
                update_hit     = upd_hit[u];
                update_hit_way = upd_way[u];
                train_reference(upd_pc[u], test_asid[t], upd_action[u], upd_payload[u],
                                upd_hit[u], upd_way[u]);
                @(posedge CLK);
                #2;
            end
        end
        update_valid = 1'b0;
        predict_reference(test_pc[t], test_asid[t], exp_valid, exp_lane, exp_target,
                          exp_next);

        // first edge loads the pc and the second returns the response
        start_valid = 1'b1;
        start_pc    = test_pc[t];
        @(posedge CLK);
        #2;
        start_valid = 1'b0;
        @(posedge CLK);
        #1;
        check_value(test_name[t], "fetch_valid", 64'd1, 64'(fetch_valid));
        check_value(test_name[t], "fetch_pc", 64'(test_pc[t]), 64'(fetch_pc));
        check_value(test_name[t], "pred_valid", 64'(exp_valid), 64'(pred_valid));
        if (exp_valid) begin
            check_value(test_name[t], "pred_lane", 64'(exp_lane), 64'(pred_lane));
            check_value(test_name[t], "pred_target", 64'(exp_target), 64'(pred_target));
        end

        // following block
        @(posedge CLK);
        #1;
        check_value(test_name[t], "next fetch_valid", 64'd1, 64'(fetch_valid));
        check_value(test_name[t], "next fetch_pc", 64'(exp_next), 64'(fetch_pc));
        #1;

        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s passed", test_name[t]);
        end
        else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name[t], test_errors);
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        void'($urandom(68071));
        CLK            = 1'b0;
        nRST           = 1'b0;
        fetch_en       = 1'b0;
        arch_asid      = '0;
        start_valid    = 1'b0;
        start_pc       = '0;
        update_valid   = 1'b0;
        update_pc      = '0;
        update_info    = '0;
        update_hit     = 1'b0;
        update_hit_way = '0;
        cycle_count    = 0;
        num_tests      = 0;
        num_updates    = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        clear_reference();
        load_tests();

        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        nRST     = 1'b1;
        fetch_en = 1'b1;

        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end

        $display("%0d tests run, %0d passed, %0d failed", num_tests, tests_passed,
                 tests_failed);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end
        else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
